// ==== dcache2.f ====
+incdir+include
verilog/dcache2_pkg.sv
verilog/dcache2_bank.sv
verilog/dcache2_way.sv
verilog/dcache2_apb.sv
verif/dcache2_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module dcache2_tb \
		-f dcache2.f -Mdir obj_dir
	out=$$(./obj_dir/Vdcache2_tb); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== verif/dcache2_tb.sv ====
`timescale 1ns/1ns

module dcache2_tb import dcache2_pkg::*; ();

  localparam int PREADY_TIMEOUT = 64; // covers the init sweep too

  logic clk, rst, psel, penable, pwrite, pready, pslverr;
  addr_t paddr;
  word_t pwdata, prdata;
  strb_t pstrb;

  // model state per set and way
  logic m_valid [SETS][WAYS];
  tag_t m_tag [SETS][WAYS];
  int m_rank [SETS][WAYS];
  word_t m_data [SETS][WAYS][BANKS];

  logic [15:0] lfsr_state;
  int checks, errors, test_errs, tests_run, tests_failed;

  dcache2_apb dcache2_apb_inst (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic void lru_touch(input int s, input int w);
    int old;
    old = m_rank[s][w];
    for (int v = 0; v < WAYS; v++) begin
      if (v == w) begin
        m_rank[s][v] = WAYS - 1;
      end else if (m_rank[s][v] > old) begin
        m_rank[s][v]--;
      end
    end
  endfunction

  // returns {pslverr, prdata}
  function automatic logic [32:0] model_access(input logic wr, input addr_t a,
                                               input word_t wd, input strb_t st);
    int s, b, hw, vw;
    tag_t t;
    s = a[7:4];
    b = a[3:2];
    t = a[15:8];
    hw = -1;
    vw = 0;
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == t) hw = w;
      if (m_rank[s][w] == 0) vw = w;
    end
    if (!wr) begin
      if (hw < 0) return {1'b1, 32'h0};
      lru_touch(s, hw);
      return {1'b0, m_data[s][hw][b]};
    end
    if (hw < 0) begin // allocate lru way, zero line
      hw = vw;
      m_valid[s][hw] = 1'b1;
      m_tag[s][hw] = t;
      for (int i = 0; i < BANKS; i++) m_data[s][hw][i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      if (st[i]) m_data[s][hw][b][8*i +: 8] = wd[8*i +: 8];
    end
    lru_touch(s, hw);
    return {1'b0, 32'h0};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      test_errs++;
      $display("Fail %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic apb_xfer(input logic wr, input addr_t a, input word_t wd, input strb_t st,
                          output word_t rd, output logic err, output logic ok);
    int cycles;
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= a;
    pwdata <= wd;
    pstrb <= st;
    @(posedge clk);
    penable <= 1'b1;
    ok = 1'b0;
    rd = '0;
    err = 1'b0;
    cycles = 0;
    while (!ok && cycles < PREADY_TIMEOUT) begin
      @(negedge clk);
      if (pready) begin
        ok = 1'b1;
        rd = prdata;
        err = pslverr;
      end
      cycles++;
    end
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    if (!ok) begin
      errors++;
      test_errs++;
      $display("timeout: no pready within %0d cycles at address %h", PREADY_TIMEOUT, a);
    end
  endtask

  task automatic access_and_check(input logic wr, input addr_t a, input word_t wd,
                                  input strb_t st, output logic got_err);
    logic [32:0] exp;
    word_t got;
    logic ok;
    exp = model_access(wr, a, wd, st);
    apb_xfer(wr, a, wd, st, got, got_err, ok);
    if (ok) begin
      check_val("pslverr", {31'b0, exp[32]}, {31'b0, got_err});
      if (!wr) check_val("prdata", exp[31:0], got);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    logic e;
    logic wr;
    word_t r, d;
    addr_t a;
    strb_t st;
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    pstrb = '0;
    lfsr_state = 16'd57;
    checks = 0;
    errors = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_rank[s][w] = w; // same start ranks as the init sweep
      end
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    access_and_check(0, 16'h1230, '0, '0, e);
    access_and_check(0, 16'h0000, '0, '0, e);
    access_and_check(0, 16'hfffc, '0, '0, e);
    access_and_check(0, 16'h5a44, '0, '0, e);
    end_test("reads miss after init");

    access_and_check(1, 16'h3424, 32'hdeadbeef, 4'hf, e);
    for (int b = 0; b < BANKS; b++) access_and_check(0, {12'h342, 2'(b), 2'b00}, '0, '0, e);
    end_test("full write then read line");

    access_and_check(1, 16'h3420, 32'h11223344, 4'hf, e);
    access_and_check(1, 16'h3420, 32'haabbccdd, 4'b0101, e);
    access_and_check(0, 16'h3420, '0, '0, e);
    access_and_check(1, 16'h3420, 32'h55667788, 4'b1010, e);
    access_and_check(0, 16'h3420, '0, '0, e);
    access_and_check(1, 16'h7728, 32'hcafef00d, 4'b0011, e); // partial write miss
    access_and_check(0, 16'h7728, '0, '0, e);
    end_test("partial strobe merge");

    for (int i = 1; i <= 4; i++) begin
      access_and_check(1, {tag_t'(16 * i), 8'h50}, 32'h0a00_0000 + i, 4'hf, e);
    end
    access_and_check(0, 16'h1050, '0, '0, e);
    access_and_check(0, 16'h2050, '0, '0, e);
    access_and_check(1, 16'h5050, 32'h0a00_0005, 4'hf, e);
    for (int i = 1; i <= 5; i++) begin
      access_and_check(0, {tag_t'(16 * i), 8'h50}, '0, '0, e);
      check_val("lru pslverr", {31'b0, i == 3}, {31'b0, e}); // tag 30 was least recent
    end
    end_test("lru replacement");

    for (int n = 0; n < 200; n++) begin
      r = take_bits(1);
      wr = r[0];
      r = take_bits(3);
      a[15:8] = {5'b00001, r[2:0]};
      r = take_bits(1);
      a[7:4] = {3'b110, r[0]};
      r = take_bits(2);
      a[3:0] = {r[1:0], 2'b00};
      r = take_bits(4);
      st = wr ? r[3:0] : 4'h0;
      d = take_bits(32);
      access_and_check(wr, a, wr ? d : '0, st, e);
    end
    end_test("random mix");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog/dcache2_apb.sv ====
`timescale 1ns/1ns

module dcache2_apb import dcache2_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  addr_t paddr,
  input  word_t pwdata,
  input  strb_t pstrb,
  output word_t prdata,
  output logic  pready,
  output logic  pslverr
);

  cache_state_t state;
  set_t init_cnt;
  logic lookup_en;

  // request held from the first access cycle
  tag_t req_tag;
  bank_t req_bank;
  word_t req_wdata;
  strb_t req_strb;
  logic req_write;

  way_mask_t way_hit;
  rank_t way_rank [WAYS];
  word_t way_rdata [WAYS];
  logic [WAYS-1:0] way_err;

  way_mask_t victim_mask;
  rank_t hit_rank_c;
  word_t rd_word;
  logic rd_err;
  logic any_hit;

  logic sel_hit;
  way_mask_t sel_mask;
  rank_t sel_rank;

  way_mask_t wr_mask;
  way_mask_t fill_mask;
  logic update_en;
  rank_t hit_rank;

  assign lookup_en = (state == st_idle) && psel && penable;
  assign any_hit = |way_hit;

  // victim is the rank 0 way, read mux picks the hit way
  always_comb begin
    victim_mask = '0;
    hit_rank_c = '0;
    rd_word = '0;
    rd_err = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      if (way_rank[w] == '0) victim_mask[w] = 1'b1;
      if (way_hit[w]) begin
        hit_rank_c = way_rank[w];
        rd_word = way_rdata[w];
        rd_err = way_err[w];
      end
    end
  end

  assign wr_mask = (state == st_merge && sel_hit) ? sel_mask : '0;
  assign fill_mask = (state == st_merge && !sel_hit) ? sel_mask : '0;
  assign update_en = (state == st_lookup && !req_write && any_hit) || state == st_merge;
  assign hit_rank = (state == st_merge) ? sel_rank : hit_rank_c;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_init;
      init_cnt <= '0;
      pready <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready <= 1'b0;
      pslverr <= 1'b0;
      case (state)
        st_init: begin
          init_cnt <= init_cnt + 1'b1;
          if (init_cnt == set_t'(SETS - 1)) state <= st_idle;
        end
        st_idle: if (lookup_en) state <= st_lookup;
        st_lookup: begin
          if (req_write) begin
            state <= st_merge;
          end else begin
            pready <= 1'b1;
            pslverr <= !any_hit || rd_err; // miss or bad syndrome
            state <= st_done;
          end
        end
        st_merge: begin
          pready <= 1'b1;
          state <= st_done;
        end
        st_done: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_en) begin
      req_tag <= paddr[15:8];
      req_bank <= paddr[3:2];
      req_wdata <= pwdata;
      req_strb <= pstrb;
      req_write <= pwrite;
    end
    if (state == st_lookup) begin
      sel_hit <= any_hit;
      sel_mask <= any_hit ? way_hit : victim_mask;
      sel_rank <= hit_rank_c; // 0 on a miss, same as the victim
      if (!req_write) prdata <= any_hit ? rd_word : '0;
    end
  end

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    dcache2_way #(
      .WAY_ID (w)
    ) way_inst (
      .clk       (clk),
      .rst       (rst),
      .init      (state == st_init),
      .init_set  (init_cnt),
      .set       (paddr[7:4]),
      .tag       (req_tag),
      .lookup_en (lookup_en),
      .bank      (req_bank),
      .wdata     (req_wdata),
      .wstrb     (req_strb),
      .write_en  (wr_mask[w]),
      .fill      (fill_mask[w]),
      .update_en (update_en),
      .hit_rank  (hit_rank),
      .hit       (way_hit[w]),
      .rank      (way_rank[w]),
      .rdata     (way_rdata[w]),
      .ecc_err   (way_err[w])
    );
  end

  a_one_hit: assert property (@(posedge clk) disable iff (rst)
    state != st_init |-> $onehot0(way_hit));

  // ranks of a set stay a permutation
  a_one_lru: assert property (@(posedge clk) disable iff (rst)
    state == st_idle |-> $onehot(victim_mask));

endmodule

// ==== verilog/dcache2_way.sv ====
`timescale 1ns/1ns

module dcache2_way import dcache2_pkg::*; #(
  parameter int WAY_ID = 0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  init,
  input  set_t  init_set,
  input  set_t  set,
  input  tag_t  tag,
  input  logic  lookup_en,
  input  bank_t bank,
  input  word_t wdata,
  input  strb_t wstrb,
  input  logic  write_en,
  input  logic  fill,
  input  logic  update_en,
  input  rank_t hit_rank,
  output logic  hit,
  output rank_t rank,
  output word_t rdata,
  output logic  ecc_err
);

  tag_t tag_mem [SETS];
  rank_t rank_mem [SETS];
  logic [SETS-1:0] valid;
  set_t set_q;
  rank_t new_rank;
  word_t bank_rdata [BANKS];
  logic [BANKS-1:0] bank_err;

  always_ff @(posedge clk) begin
    if (rst) begin
      set_q <= '0;
    end else if (lookup_en) begin
      set_q <= set;
    end
  end

  assign hit = valid[set_q] && (tag_mem[set_q] == tag);
  assign rank = rank_mem[set_q];

  // lru update, accessed way goes to the top
  always_comb begin
    if (hit || fill) begin
      new_rank = rank_t'(WAYS - 1);
    end else if (rank > hit_rank) begin
      new_rank = rank - 1'b1;
    end else begin
      new_rank = rank;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (init) begin
      valid[init_set] <= 1'b0;
    end else if (fill) begin
      valid[set_q] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) tag_mem[set_q] <= tag;
    if (init) begin
      rank_mem[init_set] <= rank_t'(WAY_ID); // distinct start ranks per way
    end else if (update_en) begin
      rank_mem[set_q] <= new_rank;
    end
  end

  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    word_t b_wdata;
    strb_t b_wstrb;
    logic b_we;

    always_comb begin
      if (!fill) begin
        b_wdata = wdata;
        b_wstrb = wstrb;
      end else if (bank == bank_t'(b)) begin
        b_wdata = byte_merge(wstrb, '0, wdata); // strobed bytes over zero
        b_wstrb = 4'hf;
      end else begin
        b_wdata = '0;
        b_wstrb = 4'hf;
      end
    end

    assign b_we = fill || (write_en && bank == bank_t'(b));

    dcache2_bank bank_inst (
      .clk     (clk),
      .rst     (rst),
      .set     (set),
      .rd_en   (lookup_en),
      .we      (b_we),
      .wdata   (b_wdata),
      .wstrb   (b_wstrb),
      .rdata   (bank_rdata[b]),
      .ecc_err (bank_err[b])
    );
  end

  assign rdata = bank_rdata[bank];
  assign ecc_err = bank_err[bank];

  a_fill_excl: assert property (@(posedge clk) disable iff (rst) !(fill && write_en));

endmodule

// ==== verilog/dcache2_bank.sv ====
`timescale 1ns/1ns

// one ECC protected word per set, write-first
module dcache2_bank import dcache2_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  set_t  set,
  input  logic  rd_en,
  input  logic  we,
  input  word_t wdata,
  input  strb_t wstrb,
  output word_t rdata,
  output logic  ecc_err
);

  ecc_word_t mem [SETS];
  set_t rd_set;
  ecc_word_t cur_word;
  word_t merged;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_set <= '0;
    end else if (rd_en) begin
      rd_set <= set;
    end
  end

  assign cur_word = mem[rd_set];
  assign rdata = cur_word[31:0];
  assign ecc_err = |ecc_syndrome(cur_word);

  // read-modify-write on the word already addressed
  assign merged = byte_merge(wstrb, cur_word[31:0], wdata);

  always_ff @(posedge clk) begin
    if (we) mem[rd_set] <= ecc_encode(merged);
  end

  // every word read back after an access must decode clean
  a_no_ecc_err: assert property (@(posedge clk) disable iff (rst)
    $past(rd_en) |-> !ecc_err);

endmodule

// ==== verilog/dcache2_pkg.sv ====
package dcache2_pkg;

  localparam int WAYS = 4;
  localparam int BANKS = 4; // words per line
  localparam int SETS = 16;

  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;
  typedef logic [15:0] addr_t; // tag 15:8, set 7:4, bank 3:2, byte 1:0
  typedef logic [3:0] set_t;
  typedef logic [7:0] tag_t;
  typedef logic [1:0] bank_t;
  typedef logic [1:0] rank_t; // 0 is least recent
  typedef logic [38:0] ecc_word_t; // check bits on top
  typedef logic [WAYS-1:0] way_mask_t;

  typedef enum logic [2:0] {st_init, st_idle, st_lookup, st_merge, st_done} cache_state_t;

  // enabled bytes from new_w, the rest from old_w
  function automatic word_t byte_merge(input strb_t strb, input word_t old_w, input word_t new_w);
    word_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  `include "dcache2_ecc.svh"

endpackage

// ==== include/dcache2_ecc.svh ====
`ifndef DCACHE2_ECC_SVH
`define DCACHE2_ECC_SVH

// hamming over code positions 1..38, powers of two hold the check bits
// check bit 6 is overall parity
function automatic ecc_word_t ecc_encode(input word_t data);
  logic [6:0] chk;
  int d;
  chk = '0;
  d = 0;
  for (int p = 1; p < 39; p++) begin
    if ((p & (p - 1)) != 0) begin
      if (data[d]) chk[5:0] ^= p[5:0]; // data bit sits at position p
      d++;
    end
  end
  chk[6] = ^{data, chk[5:0]};
  return {chk, data};
endfunction

// zero for a clean word
function automatic logic [6:0] ecc_syndrome(input ecc_word_t w);
  ecc_word_t ref_w;
  ref_w = ecc_encode(w[31:0]);
  return ref_w[38:32] ^ w[38:32];
endfunction

`endif
